/* src/dmd_settings.svh */
/*
 * Build constants for the demodulator processor interface.
 * Widths, register map, reset stretch and power-up defaults.
 * Include in any file that sizes ports or decodes registers.
 */

`ifndef DMD_SETTINGS_SVH
`define DMD_SETTINGS_SVH

// bus and converter widths
`define DMD_DATA_W        16
`define DMD_ADDR_W        12      // byte address, bit 0 never driven
`define DMD_ADC_W         14
`define DMD_DAC_W         14
`define DMD_GAIN_FRAC     14      // 16'h4000 is unity gain

// address split
`define DMD_SPACE_W       4       // addr bits 11..8
`define DMD_OFS_W         8       // addr bits 7..0

// address spaces, channel n at DMD_SPACE_CH0 + n
`define DMD_SPACE_MISC    4'h0
`define DMD_SPACE_SERIAL  4'h1
`define DMD_SPACE_CH0     4'h2

// register offsets within a space
`define DMD_REG_VERSION     8'h00
`define DMD_REG_RESET       8'h02
`define DMD_REG_SER_CMD     8'h00
`define DMD_REG_SER_STATUS  8'h02
`define DMD_REG_GAIN        8'h00
`define DMD_REG_CTRL        8'h02

// constants and defaults
`define DMD_VERSION       16'h0052
`define DMD_RESET_STRETCH 6       // soft reset length in ck933 cycles
`define DMD_GAIN_DEFAULT  16'h4000
`define DMD_DAC_MID       14'h2000 // offset binary zero
`define DMD_SCK_DIV       4       // serial clock is ck933 / 4
`define DMD_NUM_DACS      3

`endif

/* src/dmd_pkg.sv */
/*
 * Types shared by the processor bus decoder and its register blocks.
 * Import where a struct is declared or its fields are built.
 */

`include "dmd_settings.svh"

package dmd_pkg;

  // ************************************************
  // processor bus, as passed from decoder to peers
  // ************************************************

  // one bus cycle; wr is a single-cycle strobe, rd a level
  typedef struct packed {
    logic                   wr;
    logic                   rd;
    logic [`DMD_OFS_W-1:0]  offset;  // byte offset within the space
    logic [`DMD_DATA_W-1:0] wdata;
  } bus_req_t;

  // ************************************************
  // DAC serial control port
  // ************************************************

  // one serial command, 15 bits
  typedef struct packed {
    logic [1:0] sel;   // chip select, 3 is no chip
    logic [4:0] addr;  // DAC register address
    logic [7:0] data;  // DAC register data
  } dac_cmd_t;

  // ************************************************
  // channel selects
  // ************************************************

  // one bit per output channel
  typedef logic [`DMD_NUM_DACS-1:0] ch_sel_t;

endpackage

/* src/bus_decoder.sv */
/*
 * Processor bus front end. Splits the address into space and offset,
 * raises one select per mapped space and muxes read data back.
 * Reads are combinational; unmapped or idle reads give zero.
 */

`timescale 1ns/1ps
`include "dmd_settings.svh"

module bus_decoder (
  input  logic                                      ck933,
  input  logic                                      rs,
  input  logic                                      cs_n_i,
  input  logic                                      we_n_i,
  input  logic                                      rd_n_i,
  input  logic [`DMD_ADDR_W-1:1]                    addr_i,
  input  logic [`DMD_DATA_W-1:0]                    data_i,
  input  logic [`DMD_DATA_W-1:0]                    misc_rdata_i,
  input  logic [`DMD_DATA_W-1:0]                    ser_rdata_i,
  input  logic [`DMD_NUM_DACS-1:0][`DMD_DATA_W-1:0] ch_rdata_i,
  output dmd_pkg::bus_req_t                         req_o,
  output logic                                      misc_sel_o,
  output logic                                      ser_sel_o,
  output dmd_pkg::ch_sel_t                          ch_sel_o,
  output logic [`DMD_DATA_W-1:0]                    data_o
);

  logic [`DMD_ADDR_W-1:0]  byte_addr;
  logic [`DMD_SPACE_W-1:0] space;
  logic                    cs;
  logic                    wr_act;     // write cycle on the pins
  logic                    wr_q;

  assign byte_addr = {addr_i, 1'b0};
  assign space     = byte_addr[`DMD_ADDR_W-1 -: `DMD_SPACE_W];
  assign cs        = ~cs_n_i;
  assign wr_act    = cs & ~we_n_i;

  // one strobe per write even if we_n is held low
  always_ff @(posedge ck933 or posedge rs) begin
    if (rs) begin
      wr_q <= 1'b0;
    end else begin
      wr_q <= wr_act;
    end
  end

  assign req_o.wr     = wr_act & ~wr_q;
  assign req_o.rd     = cs & ~rd_n_i;
  assign req_o.offset = byte_addr[`DMD_OFS_W-1:0];
  assign req_o.wdata  = data_i;

  // ************************************************
  // space selects
  // ************************************************

  assign misc_sel_o = cs & (space == `DMD_SPACE_MISC);
  assign ser_sel_o  = cs & (space == `DMD_SPACE_SERIAL);

  always_comb begin
    for (int i = 0; i < `DMD_NUM_DACS; i++) begin
      ch_sel_o[i] = cs & (space == `DMD_SPACE_W'(`DMD_SPACE_CH0 + i));
    end
  end

  // read mux
  always_comb begin
    data_o = '0;                       // idle and unmapped read zero
    if (req_o.rd) begin
      if (space == `DMD_SPACE_MISC) begin
        data_o = misc_rdata_i;
      end else if (space == `DMD_SPACE_SERIAL) begin
        data_o = ser_rdata_i;
      end else begin
        for (int i = 0; i < `DMD_NUM_DACS; i++) begin
          if (space == `DMD_SPACE_W'(`DMD_SPACE_CH0 + i)) begin
            data_o = ch_rdata_i[i];
          end
        end
      end
    end
  end

endmodule

/* src/reset_ctrl.sv */
/*
 * Misc register space: version word and soft reset.
 * A write to the reset register holds core reset for a fixed stretch.
 */

`timescale 1ns/1ps
`include "dmd_settings.svh"

module reset_ctrl (
  input  logic                   ck933,
  input  logic                   rs,
  input  logic                   sel_i,
  input  dmd_pkg::bus_req_t      req_i,
  output logic [`DMD_DATA_W-1:0] rdata_o,
  output logic                   core_rs_o
);

  localparam int CNT_W = $clog2(`DMD_RESET_STRETCH + 1);

  logic [CNT_W-1:0] cnt_q;
  logic             soft_q;    // stretched soft reset, registered
  logic             rst_wr;

  assign rst_wr = sel_i & req_i.wr & (req_i.offset == `DMD_REG_RESET);

  // soft_q tracks cnt_q != 0 but comes straight off a flop
  always_ff @(posedge ck933 or posedge rs) begin
    if (rs) begin
      cnt_q  <= '0;
      soft_q <= 1'b0;
    end else if (rst_wr) begin
      cnt_q  <= CNT_W'(`DMD_RESET_STRETCH);
      soft_q <= 1'b1;
    end else if (cnt_q != '0) begin
      cnt_q  <= cnt_q - 1'b1;
      soft_q <= (cnt_q != CNT_W'(1));  // drops with the last count
    end
  end

  assign core_rs_o = rs | soft_q;

  // readback
  always_comb begin
    case (req_i.offset)
      `DMD_REG_VERSION: rdata_o = `DMD_VERSION;
      `DMD_REG_RESET:   rdata_o = {{(`DMD_DATA_W-1){1'b0}}, soft_q};
      default:          rdata_o = '0;
    endcase
  end

endmodule

/* src/dac_serial_port.sv */
/*
 * Write-only serial control port for the three DAC chips.
 * A command write shifts one 16-bit frame MSB first at ck933 / DMD_SCK_DIV.
 * Status bit 0 is busy; commands written while busy are dropped.
 */

`timescale 1ns/1ps
`include "dmd_settings.svh"

module dac_serial_port (
  input  logic                     ck933,
  input  logic                     rs,
  input  logic                     sel_i,
  input  dmd_pkg::bus_req_t        req_i,
  output logic [`DMD_DATA_W-1:0]   rdata_o,
  output logic                     sck_o,
  output logic                     sdio_o,
  output logic [`DMD_NUM_DACS-1:0] cs_n_o
);

  import dmd_pkg::*;

  localparam int DIV_W   = $clog2(`DMD_SCK_DIV);
  localparam int FRAME_W = 16;
  localparam int BIT_W   = $clog2(FRAME_W);

  dac_cmd_t                 cmd_in;     // fields of the bus write
  dac_cmd_t                 cmd_q;      // last accepted command
  logic                     cmd_wr;
  logic [DIV_W-1:0]         div_q;
  logic                     rise_tick;
  logic                     fall_tick;
  logic                     busy_q;
  logic                     sck_q;
  logic [FRAME_W-1:0]       shreg_q;
  logic [BIT_W-1:0]         bit_q;
  logic [`DMD_NUM_DACS-1:0] cs_n_q;

  assign cmd_in.sel  = req_i.wdata[15:14];
  assign cmd_in.addr = req_i.wdata[12:8];
  assign cmd_in.data = req_i.wdata[7:0];

  // select 3 addresses no chip
  assign cmd_wr = sel_i & req_i.wr & (req_i.offset == `DMD_REG_SER_CMD) & ~busy_q &
                  (cmd_in.sel < `DMD_NUM_DACS);

  // ************************************************
  // shift clock divider, free running
  // ************************************************

  always_ff @(posedge ck933 or posedge rs) begin
    if (rs) begin
      div_q <= '0;
    end else if (div_q == DIV_W'(`DMD_SCK_DIV - 1)) begin
      div_q <= '0;
    end else begin
      div_q <= div_q + 1'b1;
    end
  end

  assign rise_tick = (div_q == DIV_W'(`DMD_SCK_DIV / 2 - 1));
  assign fall_tick = (div_q == DIV_W'(`DMD_SCK_DIV - 1));

  // ************************************************
  // frame shifter
  // ************************************************

  // frame: write bit 0, two length bits 0, 5 addr, 8 data
  always_ff @(posedge ck933 or posedge rs) begin
    if (rs) begin
      cmd_q   <= '0;
      busy_q  <= 1'b0;
      sck_q   <= 1'b0;
      shreg_q <= '0;
      bit_q   <= '0;
      cs_n_q  <= '1;
    end else if (cmd_wr) begin
      cmd_q   <= cmd_in;
      busy_q  <= 1'b1;
      shreg_q <= {1'b0, 2'b00, cmd_in.addr, cmd_in.data};
      bit_q   <= '0;
      cs_n_q  <= ~(`DMD_NUM_DACS'(1) << cmd_in.sel);
    end else if (busy_q) begin
      if (rise_tick) begin
        sck_q <= 1'b1;
      end else if (fall_tick && sck_q) begin   // first fall waits for a rise
        sck_q <= 1'b0;
        if (bit_q == BIT_W'(FRAME_W - 1)) begin
          busy_q  <= 1'b0;                      // end of frame
          cs_n_q  <= '1;
          shreg_q <= '0;
        end else begin
          shreg_q <= shreg_q << 1;              // next bit on falling sck
          bit_q   <= bit_q + 1'b1;
        end
      end
    end
  end

  assign sck_o  = sck_q;
  assign sdio_o = shreg_q[FRAME_W-1];
  assign cs_n_o = cs_n_q;

  always_comb begin
    case (req_i.offset)
      `DMD_REG_SER_CMD:    rdata_o = {cmd_q.sel, 1'b0, cmd_q.addr, cmd_q.data};
      `DMD_REG_SER_STATUS: rdata_o = {{(`DMD_DATA_W-1){1'b0}}, busy_q};
      default:             rdata_o = '0;
    endcase
  end

endmodule

/* src/dac_channel.sv */
/*
 * One DAC output channel. Reclocks the ADC sample, scales it by a
 * signed Q2.14 gain, saturates to 14 bits and drives offset binary.
 * Three register stages, so input to pins is 3 cycles.
 */

`timescale 1ns/1ps
`include "dmd_settings.svh"

module dac_channel (
  input  logic                   ck933,
  input  logic                   rs,
  input  logic                   sel_i,
  input  dmd_pkg::bus_req_t      req_i,
  input  logic [`DMD_ADC_W-1:0]  adc_i,
  output logic [`DMD_DATA_W-1:0] rdata_o,
  output logic [`DMD_DAC_W-1:0]  dac_d_o
);

  localparam int PROD_W = `DMD_ADC_W + `DMD_DATA_W;
  localparam logic signed [PROD_W-1:0] SAT_MAX = PROD_W'(2 ** (`DMD_DAC_W - 1) - 1);
  localparam logic signed [PROD_W-1:0] SAT_MIN = -SAT_MAX - 1;

  logic signed [`DMD_DATA_W-1:0] gain_q;
  logic                          en_q;
  logic signed [`DMD_ADC_W-1:0]  adc_q;
  logic signed [PROD_W-1:0]      prod_q;
  logic signed [PROD_W-1:0]      scaled;
  logic [`DMD_DAC_W-1:0]         sat;
  logic [`DMD_DAC_W-1:0]         dac_q;

  // ************************************************
  // gain and control registers
  // ************************************************

  always_ff @(posedge ck933 or posedge rs) begin
    if (rs) begin
      gain_q <= `DMD_GAIN_DEFAULT;
      en_q   <= 1'b1;
    end else if (sel_i && req_i.wr) begin
      case (req_i.offset)
        `DMD_REG_GAIN: gain_q <= req_i.wdata;
        `DMD_REG_CTRL: en_q   <= req_i.wdata[0];
        default: ;
      endcase
    end
  end

  always_comb begin
    case (req_i.offset)
      `DMD_REG_GAIN: rdata_o = gain_q;
      `DMD_REG_CTRL: rdata_o = {{(`DMD_DATA_W-1){1'b0}}, en_q};
      default:       rdata_o = '0;
    endcase
  end

  // ************************************************
  // scaling pipeline
  // ************************************************

  always_ff @(posedge ck933) begin
    adc_q  <= adc_i;              // stage 1, reclock
    prod_q <= adc_q * gain_q;     // stage 2
  end

  assign scaled = prod_q >>> `DMD_GAIN_FRAC;

  // clip to the signed 14-bit range
  always_comb begin
    if (scaled > SAT_MAX) begin
      sat = SAT_MAX[`DMD_DAC_W-1:0];
    end else if (scaled < SAT_MIN) begin
      sat = SAT_MIN[`DMD_DAC_W-1:0];
    end else begin
      sat = scaled[`DMD_DAC_W-1:0];
    end
  end

  // stage 3, two's complement to offset binary
  always_ff @(posedge ck933 or posedge rs) begin
    if (rs) begin
      dac_q <= `DMD_DAC_MID;
    end else if (en_q) begin
      dac_q <= {~sat[`DMD_DAC_W-1], sat[`DMD_DAC_W-2:0]};
    end else begin
      dac_q <= `DMD_DAC_MID;      // disabled, hold mid-scale
    end
  end

  assign dac_d_o = dac_q;

endmodule

/* src/dmd_top.sv */
/*
 * Processor-facing top level of the demodulator board.
 * Bus decoder, version and soft reset, DAC serial port, three DAC channels.
 */

`timescale 1ns/1ps
`include "dmd_settings.svh"

module dmd_top (
  input  logic                     ck933,
  input  logic                     rs,
  input  logic                     cs_n_i,
  input  logic                     we_n_i,
  input  logic                     rd_n_i,
  input  logic [`DMD_ADDR_W-1:1]   addr_i,
  input  logic [`DMD_DATA_W-1:0]   data_i,
  input  logic [`DMD_ADC_W-1:0]    adc_d_i,
  output logic [`DMD_DATA_W-1:0]   data_o,
  output logic                     dac_rst_o,
  output logic                     dac_sck_o,
  output logic                     dac_sdio_o,
  output logic [`DMD_NUM_DACS-1:0] dac_cs_n_o,
  output logic [`DMD_DAC_W-1:0]    dac0_d_o,
  output logic [`DMD_DAC_W-1:0]    dac1_d_o,
  output logic [`DMD_DAC_W-1:0]    dac2_d_o
);

  import dmd_pkg::*;

  bus_req_t                                  req;
  logic                                      misc_sel;
  logic                                      ser_sel;
  ch_sel_t                                   ch_sel;
  logic [`DMD_DATA_W-1:0]                    misc_rdata;
  logic [`DMD_DATA_W-1:0]                    ser_rdata;
  logic [`DMD_NUM_DACS-1:0][`DMD_DATA_W-1:0] ch_rdata;
  logic                                      core_rs;   // hard or soft reset

  bus_decoder i_bus_decoder (
    .ck933, .rs,
    .cs_n_i, .we_n_i, .rd_n_i, .addr_i, .data_i,
    .misc_rdata_i (misc_rdata),
    .ser_rdata_i  (ser_rdata),
    .ch_rdata_i   (ch_rdata),
    .req_o        (req),
    .misc_sel_o   (misc_sel),
    .ser_sel_o    (ser_sel),
    .ch_sel_o     (ch_sel),
    .data_o
  );

  reset_ctrl i_reset_ctrl (
    .ck933, .rs,
    .sel_i (misc_sel), .req_i (req),
    .rdata_o (misc_rdata), .core_rs_o (core_rs)
  );

  assign dac_rst_o = core_rs;   // DAC chips reset with the core

  dac_serial_port i_dac_serial_port (
    .ck933, .rs (core_rs),
    .sel_i (ser_sel), .req_i (req),
    .rdata_o (ser_rdata),
    .sck_o (dac_sck_o), .sdio_o (dac_sdio_o), .cs_n_o (dac_cs_n_o)
  );

  dac_channel i_dac_channel0 (
    .ck933, .rs (core_rs), .sel_i (ch_sel[0]), .req_i (req),
    .adc_i (adc_d_i), .rdata_o (ch_rdata[0]), .dac_d_o (dac0_d_o)
  );

  dac_channel i_dac_channel1 (
    .ck933, .rs (core_rs), .sel_i (ch_sel[1]), .req_i (req),
    .adc_i (adc_d_i), .rdata_o (ch_rdata[1]), .dac_d_o (dac1_d_o)
  );

  dac_channel i_dac_channel2 (
    .ck933, .rs (core_rs), .sel_i (ch_sel[2]), .req_i (req),
    .adc_i (adc_d_i), .rdata_o (ch_rdata[2]), .dac_d_o (dac2_d_o)
  );

endmodule

/* verif/tb_dmd.sv */
/*
 * Directed testbench for the demodulator processor interface.
 * Drives the register bus and ADC input, checks registers, DAC pins,
 * the serial control frame and the soft reset.
 */

`timescale 1ns/1ps
`include "dmd_settings.svh"

module tb_dmd;

  logic ck933, rs, cs_n_i, we_n_i, rd_n_i;
  logic [10:0] addr_i;
  logic [15:0] data_i, data_o;
  logic [13:0] adc_d_i, dac0_d_o, dac1_d_o, dac2_d_o;
  logic        dac_rst_o, dac_sck_o, dac_sdio_o;
  logic [2:0]  dac_cs_n_o;
  logic [15:0] gain_set [3];    // gains last written per channel
  int          seed = 32'hc95a;
  int          checks = 0;
  int          errors = 0;

  dmd_top i_dmd_top (.*);

  initial begin
    ck933 = 1'b0;
    forever #4 ck933 = ~ck933;
  end

  // ************************************************
  // bus and check helpers
  // ************************************************

  task automatic check(input string name, input logic [31:0] actual,
                       input logic [31:0] expected);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("Fail %s: got %h expected %h", name, actual, expected);
    end
  endtask

  task automatic report_timeout(input string what);
    errors++;
    $display("timeout while waiting for %s", what);
  endtask

  task automatic bus_write(input logic [3:0] space, input logic [7:0] ofs,
                           input logic [15:0] wdata);
    logic [11:0] byte_addr;
    byte_addr = {space, ofs};
    @(posedge ck933);
    cs_n_i <= 1'b0;
    we_n_i <= 1'b0;
    addr_i <= byte_addr[11:1];
    data_i <= wdata;
    @(posedge ck933);           // write lands on this edge
    cs_n_i <= 1'b1;
    we_n_i <= 1'b1;
  endtask

  task automatic bus_read(input logic [3:0] space, input logic [7:0] ofs,
                          output logic [15:0] rdata);
    logic [11:0] byte_addr;
    byte_addr = {space, ofs};
    @(posedge ck933);
    cs_n_i <= 1'b0;
    rd_n_i <= 1'b0;
    addr_i <= byte_addr[11:1];
    @(negedge ck933);
    rdata = data_o;
    @(posedge ck933);
    cs_n_i <= 1'b1;
    rd_n_i <= 1'b1;
  endtask

  task automatic wait_not_busy;
    logic [15:0] st;
    int          n;
    st = 16'h1;
    n = 0;
    while (st[0] && n < 200) begin
      bus_read(`DMD_SPACE_SERIAL, `DMD_REG_SER_STATUS, st);
      n++;
    end
    if (st[0]) report_timeout("serial port busy to clear");
  endtask

  // shift one bit in per sck rise while the chosen chip is selected
  task automatic capture_frame(input logic [2:0] mask, output logic [15:0] frame,
                               output logic [2:0] cs_low);
    logic sck_prev;
    int   nbits;
    int   cyc;
    frame = '0;
    cs_low = '0;
    sck_prev = dac_sck_o;
    nbits = 0;
    cyc = 0;
    while (nbits < 16 && cyc < 200) begin
      @(negedge ck933);
      cyc++;
      cs_low = cs_low | ~dac_cs_n_o;
      if ((dac_cs_n_o & mask) == 3'b000 && dac_sck_o && !sck_prev) begin
        frame = {frame[14:0], dac_sdio_o};
        nbits++;
      end
      sck_prev = dac_sck_o;
    end
    if (nbits < 16) report_timeout("16 bits of serial frame");
  endtask

  // scale, clip to signed 14 bits, then shift into offset binary
  function automatic logic [13:0] scale_expect(input logic [13:0] sample,
                                               input logic [15:0] gain);
    int y;
    y = (int'($signed(sample)) * int'($signed(gain))) >>> 14;
    if (y > 8191) y = 8191;
    else if (y < -8192) y = -8192;
    return 14'(y + 8192);
  endfunction

  function automatic logic [13:0] dac_pin(input logic [1:0] c);
    case (c)
      2'd0:    return dac0_d_o;
      2'd1:    return dac1_d_o;
      default: return dac2_d_o;
    endcase
  endfunction

  // hold a sample and check every channel 3 cycles after it is driven
  task automatic apply_sample(input logic [13:0] sample, input logic [2:0] en);
    logic [1:0] c;
    @(posedge ck933);
    adc_d_i <= sample;
    repeat (3) @(posedge ck933);
    @(negedge ck933);
    for (c = 0; c < 3; c++) begin
      check($sformatf("dac%0d_d_o", c), 32'(dac_pin(c)),
            en[c] ? 32'(scale_expect(sample, gain_set[c])) : 32'h2000);
    end
  endtask

  task automatic set_gain(input logic [1:0] c, input logic [15:0] g);
    logic [15:0] rd;
    gain_set[c] = g;
    bus_write(4'(`DMD_SPACE_CH0 + c), `DMD_REG_GAIN, g);
    bus_read(4'(`DMD_SPACE_CH0 + c), `DMD_REG_GAIN, rd);
    check($sformatf("ch%0d gain", c), 32'(rd), 32'(g));
  endtask

  // ************************************************
  // tests
  // ************************************************

  task automatic read_reset_values;
    logic [15:0] rd;
    logic [1:0]  c;
    check("dac_cs_n_o", 32'(dac_cs_n_o), 32'h7);
    check("dac_sck_o", 32'(dac_sck_o), 32'h0);
    check("dac_sdio_o", 32'(dac_sdio_o), 32'h0);
    bus_read(`DMD_SPACE_MISC, `DMD_REG_VERSION, rd);
    check("version", 32'(rd), 32'h0052);
    bus_read(`DMD_SPACE_SERIAL, `DMD_REG_SER_STATUS, rd);
    check("serial busy", 32'(rd), 32'h0);
    for (c = 0; c < 3; c++) begin
      bus_read(4'(`DMD_SPACE_CH0 + c), `DMD_REG_GAIN, rd);
      check($sformatf("ch%0d gain", c), 32'(rd), 32'h4000);
      bus_read(4'(`DMD_SPACE_CH0 + c), `DMD_REG_CTRL, rd);
      check($sformatf("ch%0d ctrl", c), 32'(rd), 32'h1);
    end
    bus_read(4'h5, 8'h00, rd);  // first space past the channels
    check("unmapped space 5", 32'(rd), 32'h0);
    bus_read(4'hf, 8'h02, rd);
    check("unmapped space f", 32'(rd), 32'h0);
  endtask

  task automatic scale_random_gains;
    int          r;
    logic [13:0] sample;
    for (r = 0; r < 6; r++) begin
      set_gain(2'd0, 16'($random(seed)));
      if (r < 2) begin            // full scale against max gains hits both rails
        set_gain(2'd1, 16'h7fff);
        set_gain(2'd2, 16'h8000);
        sample = (r == 0) ? 14'h1fff : 14'h2001;
      end else begin
        set_gain(2'd1, 16'($random(seed)));
        set_gain(2'd2, 16'($random(seed)));
        sample = 14'($random(seed));
      end
      apply_sample(sample, 3'b111);
    end
  endtask

  task automatic toggle_channel_enable;
    logic [15:0] rd;
    bus_write(4'(`DMD_SPACE_CH0 + 1), `DMD_REG_CTRL, 16'h0000);
    bus_read(4'(`DMD_SPACE_CH0 + 1), `DMD_REG_CTRL, rd);
    check("ch1 ctrl", 32'(rd), 32'h0);
    apply_sample(14'($random(seed)), 3'b101);
    apply_sample(14'($random(seed)), 3'b101);
    bus_write(4'(`DMD_SPACE_CH0 + 1), `DMD_REG_CTRL, 16'h0001);
    apply_sample(14'($random(seed)), 3'b111);
  endtask

  task automatic send_serial_frames;
    logic [15:0] cmd, frame;
    logic [2:0]  mask, cs_low;
    logic        sck_seen;
    int          s;
    for (s = 0; s < 3; s++) begin
      cmd = 16'($random(seed));
      cmd[15:14] = 2'(s);
      mask = 3'b001 << s;
      bus_write(`DMD_SPACE_SERIAL, `DMD_REG_SER_CMD, cmd);
      capture_frame(mask, frame, cs_low);
      // write bit, two length bits, then address and data
      check($sformatf("sdio frame sel %0d", s), 32'(frame),
            {16'h0, 1'b0, 2'b00, cmd[12:8], cmd[7:0]});
      check($sformatf("cs_n low sel %0d", s), 32'(cs_low), 32'(mask));
      wait_not_busy();
      check("dac_cs_n_o idle", 32'(dac_cs_n_o), 32'h7);
    end
    bus_write(`DMD_SPACE_SERIAL, `DMD_REG_SER_CMD, 16'hc0a5);
    cs_low = '0;
    sck_seen = 1'b0;
    repeat (40) begin
      @(negedge ck933);
      cs_low = cs_low | ~dac_cs_n_o;
      sck_seen = sck_seen | dac_sck_o;
    end
    check("cs_n low sel 3", 32'(cs_low), 32'h0);
    check("dac_sck_o sel 3", 32'(sck_seen), 32'h0);
    wait_not_busy();
  endtask

  task automatic pulse_soft_reset;
    logic [15:0] rd;
    logic [1:0]  c;
    int          n, cyc;
    logic        done;
    for (c = 0; c < 3; c++) set_gain(c, 16'h1234 + 16'(c));
    bus_write(4'(`DMD_SPACE_CH0 + 2), `DMD_REG_CTRL, 16'h0000);
    bus_write(`DMD_SPACE_MISC, `DMD_REG_RESET, 16'h0001);
    n = 0;
    cyc = 0;
    done = 1'b0;
    while (!done && cyc < 50) begin
      @(negedge ck933);
      cyc++;
      if (dac_rst_o) n++;
      else done = 1'b1;
    end
    if (!done) report_timeout("dac_rst_o to fall");
    check("dac_rst_o high cycles", 32'(n), 32'd6);
    for (c = 0; c < 3; c++) begin
      gain_set[c] = 16'h4000;
      bus_read(4'(`DMD_SPACE_CH0 + c), `DMD_REG_GAIN, rd);
      check($sformatf("ch%0d gain after reset", c), 32'(rd), 32'h4000);
      bus_read(4'(`DMD_SPACE_CH0 + c), `DMD_REG_CTRL, rd);
      check($sformatf("ch%0d ctrl after reset", c), 32'(rd), 32'h1);
    end
    apply_sample(14'h0abc, 3'b111);   // unity gain again
  endtask

  initial begin
    rs = 1'b1;
    cs_n_i = 1'b1;
    we_n_i = 1'b1;
    rd_n_i = 1'b1;
    addr_i = '0;
    data_i = '0;
    adc_d_i = '0;
    repeat (8) @(posedge ck933);
    rs <= 1'b0;
    repeat (2) @(posedge ck933);
    read_reset_values();
    scale_random_gains();
    toggle_channel_enable();
    send_serial_frames();
    pulse_soft_reset();
    $display("checks %0d errors %0d", checks, errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

/* files.f */
+incdir+src
src/dmd_pkg.sv
src/bus_decoder.sv
src/reset_ctrl.sv
src/dac_serial_port.sv
src/dac_channel.sv
src/dmd_top.sv
verif/tb_dmd.sv

/* run_sim.sh */
#!/bin/sh
# build the testbench with Verilator, run it, pass only if the pass line shows up
cd "$(dirname "$0")" &&
verilator --binary --timing --timescale 1ns/1ps -f files.f --top-module tb_dmd -o tb_dmd &&
./obj_dir/tb_dmd | tee /dev/stderr | grep -q -F '** PASS **' &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
